//--- dv/umtrx_core_tb.sv
// Acts as the only bus master; RAM data comes from seeded $urandom and PPS is raised once
`timescale 1ns/1ns
`include "umtrx_macros.svh"

module umtrx_core_tb
   import wb_bus_pkg::*;
   import radio_ctrl_pkg::*;
();

   localparam int TIMEOUT = 20;   // Cycles or polls per wait

   typedef enum {OP_WR, OP_RD, OP_SET, OP_ERR, OP_OUTS, OP_PINS, OP_BOOT} op_e;

   typedef struct packed {
      op_e         op;
      logic [15:0] adr;    // Byte address
      logic [31:0] wdat;
      logic [31:0] exp;
      logic [31:0] mask;   // Bits compared on reads
   } entry_t;

   logic        wb_clk = 1'b0;
   logic        por_rst;
   wb_addr_u    m_adr;
   logic [31:0] m_wdat;
   logic [3:0]  m_sel;
   logic        m_we, m_cyc, m_stb;
   logic        pps, button;
   logic [3:0]  run;
   logic [1:0]  aux_ld;
   logic [31:0] m_dat_o;
   logic        m_ack_o, m_err_o, wb_rst_o, phy_reset_n_o;
   led_vec_t    leds_o;
   logic [1:0]  div_sw_o, lms_res_o;

   entry_t      tbl[$];
   int          errors;
   int          checks;

   // Expected settings outputs
   led_vec_t    m_src;
   led_vec_t    m_sw;
   logic        m_phy_n;
   logic [1:0]  m_lms;
   logic [1:0]  m_div;

   umtrx_core dut (
      .wb_clk(wb_clk), .por_rst(por_rst), .m_adr_i(m_adr), .m_dat_i(m_wdat),
      .m_sel_i(m_sel), .m_we_i(m_we), .m_cyc_i(m_cyc), .m_stb_i(m_stb), .pps_i(pps),
      .run_i(run), .button_i(button), .aux_ld_i(aux_ld), .m_dat_o(m_dat_o),
      .m_ack_o(m_ack_o), .m_err_o(m_err_o), .wb_rst_o(wb_rst_o), .leds_o(leds_o),
      .div_sw_o(div_sw_o), .phy_reset_n_o(phy_reset_n_o), .lms_res_o(lms_res_o));

   always #50 wb_clk = ~wb_clk;   // 100 ns period

   ////////////////////////////////////////
   // Bus and check helpers
   task automatic step();   // To the drive point of the next cycle
      @(posedge wb_clk);
      #5;
   endtask

   task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] got);
      checks++;
      assert (got === exp) else begin
         $display("ERROR at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat, output logic acked, output logic erred);
      int n;
      n = 0;
      acked = 1'b0;
      erred = 1'b0;
      rdat = '0;
      m_adr.flat = adr;
      m_wdat = wdat;
      m_we = we;
      m_sel = 4'hF;
      m_cyc = 1'b1;
      m_stb = 1'b1;
      while (!acked && !erred && n < TIMEOUT) begin
         step();
         acked = m_ack_o;
         erred = m_err_o;
         rdat = m_dat_o;   // Valid with ack
         n++;
      end
      m_cyc = 1'b0;
      m_stb = 1'b0;
      m_we = 1'b0;
      assert (acked || erred) else begin
         $display("Timeout: no ack or error for access to address %h", adr);
         errors++;
      end
   endtask

   task automatic read_word(input logic [15:0] adr, output logic [31:0] val);
      logic acked, erred;
      bus_cycle(1'b0, adr, 32'h0, val, acked, erred);
      check_eq("m_ack_o", 1, acked);
   endtask

   function automatic logic [15:0] set_adr(input set_addr_t r);
      return 16'h7000 + {6'b0, r, 2'b00};   // Word per register
   endfunction

   function automatic led_vec_t expected_leds(led_vec_t src, led_vec_t sw, logic [3:0] r);
      led_vec_t hw;
      led_vec_t leds;
      hw = '0;
      hw[4:1] = r;   // tx0 down to rx1
      for (int i = 0; i < 8; i++) begin
         leds[i] = src[i] ? hw[i] : sw[i];
      end
      return leds;
   endfunction

   task automatic model_reset();
      m_src = 8'h1E;
      m_sw = '0;
      m_phy_n = 1'b1;
      m_lms = 2'b00;
      m_div = 2'b11;
   endtask

   task automatic model_set(input set_addr_t r, input logic [31:0] d);
      case (r)
         `SR_MISC + 8'd0:  m_lms = d[6:5];
         `SR_MISC + 8'd3:  m_sw = d[7:0];
         `SR_MISC + 8'd4:  m_phy_n = ~d[0];
         `SR_MISC + 8'd6:  m_src = d[7:0];
         `SR_DIVSW + 8'd0: m_div[0] = d[0];
         `SR_DIVSW + 8'd1: m_div[1] = d[0];
         default: ;
      endcase
   endtask

   task automatic check_outputs();   // Random run flags
      for (int k = 0; k < 4; k++) begin
         run = $urandom;
         step();
         check_eq("leds_o", expected_leds(m_src, m_sw, run), leds_o);
         check_eq("div_sw_o", m_div, div_sw_o);
         check_eq("phy_reset_n_o", m_phy_n, phy_reset_n_o);
         check_eq("lms_res_o", m_lms, lms_res_o);
      end
   endtask

   ////////////////////////////////////////
   // Stimulus table
   task automatic add(op_e op, logic [15:0] adr, logic [31:0] wd, logic [31:0] ex,
                      logic [31:0] mk);
      entry_t e;
      e.op = op;
      e.adr = adr;
      e.wdat = wd;
      e.exp = ex;
      e.mask = mk;
      tbl.push_back(e);
   endtask

   task automatic build_table();
      logic [31:0] w0, w1;
      w0 = $urandom;
      w1 = $urandom;
      add(OP_OUTS, 0, 0, 0, 0);                                   // Reset values
      add(OP_RD, 16'h5C30, 0, `COMPAT_NUM, 32'hFFFF_FFFF);
      add(OP_SET, set_adr(`SR_MISC + 8'd3), 32'hA5, 0, 0);        // Software LEDs
      add(OP_SET, set_adr(`SR_MISC + 8'd6), 32'h0F, 0, 0);
      add(OP_SET, set_adr(`SR_MISC + 8'd4), 32'h1, 0, 0);         // PHY in reset
      add(OP_SET, set_adr(`SR_MISC + 8'd0), 32'h40, 0, 0);
      add(OP_SET, set_adr(`SR_DIVSW), 32'h0, 0, 0);
      add(OP_OUTS, 0, 0, 0, 0);
      add(OP_SET, set_adr(`SR_MISC + 8'd6), 32'hF0, 0, 0);
      add(OP_SET, set_adr(`SR_DIVSW + 8'd1), 32'h0, 0, 0);
      add(OP_SET, set_adr(`SR_MISC + 8'd0), 32'h20, 0, 0);
      add(OP_OUTS, 0, 0, 0, 0);
      add(OP_PINS, 0, 32'h5, 0, 0);                               // {ld2, ld1, button}
      add(OP_RD, 16'h5C34, 0, 32'h5 << 13, 32'h0000_E000);
      add(OP_PINS, 0, 32'h2, 0, 0);
      add(OP_RD, 16'h5C34, 0, 32'h2 << 13, 32'h0000_E000);
      add(OP_ERR, 16'h9000, 0, 0, 0);                             // Unmapped page
      add(OP_WR, 16'h0010, w0, 0, 0);                             // Lands in boot RAM
      add(OP_RD, 16'h0010, 0, w0, 32'hFFFF_FFFF);
      add(OP_BOOT, set_adr(`SR_MISC + 8'd5), 32'h1, 0, 0);
      add(OP_OUTS, 0, 0, 0, 0);
      add(OP_RD, 16'hC010, 0, w0, 32'hFFFF_FFFF);                 // Swap gone
      add(OP_WR, 16'h0010, w1, 0, 0);
      add(OP_RD, 16'h0010, 0, w1, 32'hFFFF_FFFF);
      add(OP_RD, 16'hC010, 0, w0, 32'hFFFF_FFFF);
   endtask

   task automatic run_entry(input entry_t e);
      logic [31:0] rdat;
      logic        acked, erred;
      int          n;
      case (e.op)
         OP_WR, OP_SET: begin
            bus_cycle(1'b1, e.adr, e.wdat, rdat, acked, erred);
            check_eq("m_ack_o", 1, acked);
            if (e.op == OP_SET) model_set(e.adr[9:2], e.wdat);
         end
         OP_RD: begin
            bus_cycle(1'b0, e.adr, 32'h0, rdat, acked, erred);
            check_eq("m_ack_o", 1, acked);
            check_eq("m_dat_o", e.exp & e.mask, rdat & e.mask);
         end
         OP_ERR: begin
            bus_cycle(1'b0, e.adr, 32'h0, rdat, acked, erred);
            check_eq("m_err_o", 1, erred);
            check_eq("m_ack_o", 0, acked);
         end
         OP_PINS: begin
            aux_ld = e.wdat[2:1];
            button = e.wdat[0];
         end
         OP_BOOT: begin
            bus_cycle(1'b1, e.adr, e.wdat, rdat, acked, erred);
            n = 0;
            while (!wb_rst_o && n < TIMEOUT) begin   // No bus cycle meanwhile
               step();
               n++;
            end
            assert (wb_rst_o) else begin
               $display("Timeout: wb_rst_o never pulsed after bootloader done");
               errors++;
            end
            step();
            check_eq("wb_rst_o", 0, wb_rst_o);   // Single cycle pulse
            model_reset();
         end
         default: check_outputs();
      endcase
   endtask

   ////////////////////////////////////////
   // Timer load and PPS latch
   task automatic timer_test();
      logic [31:0] hi, lo, v, th, pl, ph;
      logic [63:0] t0, t1, tp;
      int          n;
      hi = $urandom;
      lo = $urandom & 32'h0FFF_FFFF;   // No carry into hi
      run_entry('{OP_SET, set_adr(`SR_TIME64), hi, 0, 0});
      run_entry('{OP_SET, set_adr(`SR_TIME64 + 8'd1), lo, 0, 0});
      read_word(16'h5C28, v);
      check_eq("m_dat_o word 10", hi, v);
      read_word(16'h5C2C, v);
      checks++;
      assert (v >= lo && v < lo + 50) else begin
         $display("ERROR at %0t ns: m_dat_o word 11 expected %0h to %0h got %0h", $time, lo,
                  lo + 49, v);
         errors++;
      end
      read_word(16'h5C28, th);
      read_word(16'h5C2C, v);
      t0 = {th, v};
      pps = 1'b1;
      pl = '0;
      n = 0;
      while (pl == 0 && n < TIMEOUT) begin   // Wait out the synchronizer
         read_word(16'h5C3C, pl);
         n++;
      end
      assert (pl != 0) else begin
         $display("Timeout: PPS time was never latched");
         errors++;
      end
      read_word(16'h5C28, th);
      read_word(16'h5C2C, v);
      t1 = {th, v};
      read_word(16'h5C38, ph);
      tp = {ph, pl};
      checks++;
      assert (tp >= t0 && tp <= t1) else begin
         $display("ERROR at %0t ns: m_dat_o words 14 and 15 expected %0h to %0h got %0h",
                  $time, t0, t1, tp);
         errors++;
      end
      pps = 1'b0;
   endtask

   initial begin
      int n;
      errors = 0;
      checks = 0;
      por_rst = 1'b1;
      m_adr = '0;
      m_wdat = '0;
      m_sel = '0;
      m_we = 1'b0;
      m_cyc = 1'b0;
      m_stb = 1'b0;
      pps = 1'b0;
      run = '0;
      button = 1'b0;
      aux_ld = '0;
      void'($urandom(32'h68fd_2715));
      model_reset();
      build_table();
      repeat (3) @(posedge wb_clk);
      #5;
      por_rst = 1'b0;
      n = 0;
      while (wb_rst_o && n < TIMEOUT) begin
         step();
         n++;
      end
      assert (!wb_rst_o) else begin
         $display("Timeout: wb_rst_o stayed high after power-on reset");
         errors++;
      end
      check_eq("m_ack_o", 0, m_ack_o);
      check_eq("m_err_o", 0, m_err_o);
      foreach (tbl[i]) begin
         run_entry(tbl[i]);
      end
      timer_test();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- source/boot_reset_ctrl.sv
// Boot RAM answers at page 0 until the bootloader reports done; only por_rst brings the swap back
`timescale 1ns/1ns
`include "umtrx_macros.svh"

module boot_reset_ctrl
   import wb_bus_pkg::*;
(
   input  logic     wb_clk,
   input  logic     por_rst,
   input  logic     bldr_done_i,   // Flag from the settings bus
   input  wb_addr_u cpu_adr_i,     // As driven by the master
   output wb_addr_u bus_adr_o,     // As seen by the decoder
   output logic     wb_rst_o
);

   localparam logic ST_WAIT = 1'b0;   // Bootloader still running
   localparam logic ST_DONE = 1'b1;   // Swap ended for good

   logic state_q;
   logic core_rst_q;

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state_q    <= ST_WAIT;
         core_rst_q <= 1'b1;            // Core held during POR
      end else begin
         core_rst_q <= 1'b0;            // Default low, pulses are one cycle
         if (state_q == ST_WAIT && bldr_done_i) begin
            state_q    <= ST_DONE;
            core_rst_q <= 1'b1;         // Restart the core on the main image
         end
      end
   end

   assign wb_rst_o = core_rst_q;

   ////////////////////////////////////////
   // Address swap
   // Equal top bits select the 0K or 48K region, flip both while waiting
   always_comb begin
      bus_adr_o = cpu_adr_i;
      if (state_q == ST_WAIT &&
          cpu_adr_i.flat[`UMTRX_AW-1] == cpu_adr_i.flat[`UMTRX_AW-2]) begin
         bus_adr_o.flat = cpu_adr_i.flat ^ {2'b11, {(`UMTRX_AW-2){1'b0}}};
      end
   end

endmodule

//--- source/radio_ctrl_pkg.sv
// Radio control types; every value here lives in the wb_clk domain
package radio_ctrl_pkg;

   // Settings register number, word offset in the settings page
   typedef logic [7:0] set_addr_t;

   // Front panel LEDs, one bit each
   typedef logic [7:0] led_vec_t;

   // VITA time in wb_clk ticks
   typedef logic [63:0] vita_time_t;

endpackage

//--- source/readback_mux.sv
// Read-only slave; writes are acked and dropped, and unlisted words read as zero
`timescale 1ns/1ns
`include "umtrx_macros.svh"

module readback_mux
   import radio_ctrl_pkg::*;
(
   input  logic                 wb_clk,
   input  logic                 wb_rst_i,
   input  logic                 stb_i,
   input  logic [3:0]           adr_i,       // Word index
   input  vita_time_t           vita_time_i,
   input  vita_time_t           vita_time_pps_i,
   input  logic                 button_i,
   input  logic [1:0]           aux_ld_i,    // LD2, LD1
   output logic [`UMTRX_DW-1:0] dat_o,
   output logic                 ack_o
);

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= stb_i & ~ack_o;
      end
   end

   // Word select, valid with ack
   always_ff @(posedge wb_clk) begin
      case (adr_i)
         4'd10:   dat_o <= vita_time_i[63:32];
         4'd11:   dat_o <= vita_time_i[31:0];
         4'd12:   dat_o <= `COMPAT_NUM;
         4'd13:   dat_o <= {16'b0, aux_ld_i[1], aux_ld_i[0], button_i, 13'b0};
         4'd14:   dat_o <= vita_time_pps_i[63:32];
         4'd15:   dat_o <= vita_time_pps_i[31:0];
         default: dat_o <= '0;   // Status words not built here
      endcase
   end

endmodule

//--- source/settings_regs.sv
// Write-only settings page, reads ack with zero; the settings strobe is combinational off the bus
`timescale 1ns/1ns
`include "umtrx_macros.svh"

module settings_regs
   import radio_ctrl_pkg::*;
(
   input  logic                 wb_clk,
   input  logic                 wb_rst_i,
   input  logic                 stb_i,
   input  logic                 we_i,
   input  set_addr_t            adr_i,         // Word offset in the page
   input  logic [`UMTRX_DW-1:0] dat_i,
   output logic                 ack_o,
   output logic                 set_stb_o,     // One cycle per write
   output set_addr_t            set_addr_o,
   output logic [`UMTRX_DW-1:0] set_data_o,
   input  logic [3:0]           run_i,         // tx0, rx0, tx1, rx1
   output led_vec_t             leds_o,
   output logic [1:0]           div_sw_o,
   output logic                 phy_reset_n_o,
   output logic [1:0]           lms_res_o,
   output logic                 bldr_done_o
);

   logic       wr;            // Accepted write
   led_vec_t   led_sw_q;      // Software LED values
   led_vec_t   led_src_q;     // 1 selects hardware
   led_vec_t   led_hw;
   logic       phy_reset_q;   // Active high inside
   logic [1:0] lms_res_q;     // Clock-out bits 6:5
   logic [1:0] div_sw_q;
   logic       bldr_done_q;

   assign wr = stb_i & we_i & ~ack_o;

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= stb_i & ~ack_o;   // Reads ack too
      end
   end

   // Forward to the other settings consumers, same edge as our own regs
   assign set_stb_o  = wr;
   assign set_addr_o = adr_i;
   assign set_data_o = dat_i;

   ////////////////////////////////////////
   // Control registers
   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         lms_res_q   <= 2'b00;
         led_sw_q    <= '0;
         phy_reset_q <= 1'b0;
         bldr_done_q <= 1'b0;
         led_src_q   <= `LED_SRC_RESET;
         div_sw_q    <= 2'b11;        // Both switches on
      end else if (wr) begin
         case (adr_i)
            `SR_MISC + 8'd0:  lms_res_q   <= dat_i[6:5];   // Other clock-outs unpinned
            `SR_MISC + 8'd3:  led_sw_q    <= dat_i[7:0];
            `SR_MISC + 8'd4:  phy_reset_q <= dat_i[0];
            `SR_MISC + 8'd5:  bldr_done_q <= dat_i[0];
            `SR_MISC + 8'd6:  led_src_q   <= dat_i[7:0];
            `SR_DIVSW + 8'd0: div_sw_q[0] <= dat_i[0];
            `SR_DIVSW + 8'd1: div_sw_q[1] <= dat_i[0];
            default: ;                     // Not ours, timer or unused
         endcase
      end
   end

   ////////////////////////////////////////
   // LED mux
   assign led_hw = {3'b000, run_i, 1'b0};   // Run flags on bits 4:1
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   assign div_sw_o      = div_sw_q;
   assign phy_reset_n_o = ~phy_reset_q;
   assign lms_res_o     = lms_res_q;
   assign bldr_done_o   = bldr_done_q;

endmodule

//--- source/umtrx_core.sv
// Wishbone master is the top port; hold every request until m_ack_o or m_err_o, never during wb_rst_o
`timescale 1ns/1ns
`include "umtrx_macros.svh"

module umtrx_core
   import wb_bus_pkg::*;
   import radio_ctrl_pkg::*;
(
   input  logic                 wb_clk,
   input  logic                 por_rst,
   input  wb_addr_u             m_adr_i,
   input  logic [`UMTRX_DW-1:0] m_dat_i,
   input  logic [`UMTRX_SW-1:0] m_sel_i,
   input  logic                 m_we_i,
   input  logic                 m_cyc_i,
   input  logic                 m_stb_i,
   input  logic                 pps_i,
   input  logic [3:0]           run_i,       // tx0, rx0, tx1, rx1
   input  logic                 button_i,
   input  logic [1:0]           aux_ld_i,
   output logic [`UMTRX_DW-1:0] m_dat_o,
   output logic                 m_ack_o,
   output logic                 m_err_o,
   output logic                 wb_rst_o,
   output led_vec_t             leds_o,
   output logic [1:0]           div_sw_o,
   output logic                 phy_reset_n_o,
   output logic [1:0]           lms_res_o
);

   wb_addr_u                  bus_adr;   // After the boot swap
   logic [3:0]                s_stb;
   logic [3:0]                s_ack;
   logic [3:0][`UMTRX_DW-1:0] s_dat;
   logic                      bldr_done;
   logic                      set_stb;
   set_addr_t                 set_addr;
   logic [`UMTRX_DW-1:0]      set_data;
   vita_time_t                vita_time;
   vita_time_t                vita_time_pps;

   ////////////////////////////////////////
   // Reset and swap
   boot_reset_ctrl u_boot_ctrl (
      .wb_clk(wb_clk), .por_rst(por_rst), .bldr_done_i(bldr_done),
      .cpu_adr_i(m_adr_i), .bus_adr_o(bus_adr), .wb_rst_o(wb_rst_o));

   wb_intercon u_intercon (
      .wb_clk(wb_clk), .wb_rst_i(wb_rst_o), .m_adr_i(bus_adr),
      .m_cyc_i(m_cyc_i), .m_stb_i(m_stb_i), .m_ack_o(m_ack_o), .m_err_o(m_err_o),
      .m_dat_o(m_dat_o), .s_stb_o(s_stb), .s_ack_i(s_ack), .s_dat_i(s_dat));

   ////////////////////////////////////////
   // Memories
   wb_ram #(.AW(`UMTRX_RAM_AW)) u_main_ram (
      .wb_clk(wb_clk), .wb_rst_i(wb_rst_o), .stb_i(s_stb[MAIN]), .we_i(m_we_i),
      .sel_i(m_sel_i), .adr_i(bus_adr.flat[`UMTRX_RAM_AW+1:2]), .dat_i(m_dat_i),
      .dat_o(s_dat[MAIN]), .ack_o(s_ack[MAIN]));

   wb_ram #(.AW(`UMTRX_RAM_AW)) u_boot_ram (
      .wb_clk(wb_clk), .wb_rst_i(wb_rst_o), .stb_i(s_stb[BOOT]), .we_i(m_we_i),
      .sel_i(m_sel_i), .adr_i(bus_adr.flat[`UMTRX_RAM_AW+1:2]), .dat_i(m_dat_i),
      .dat_o(s_dat[BOOT]), .ack_o(s_ack[BOOT]));

   ////////////////////////////////////////
   // Settings, time and readback
   settings_regs u_settings (
      .wb_clk(wb_clk), .wb_rst_i(wb_rst_o), .stb_i(s_stb[SET]), .we_i(m_we_i),
      .adr_i(bus_adr.flat[9:2]), .dat_i(m_dat_i), .ack_o(s_ack[SET]),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .run_i(run_i), .leds_o(leds_o), .div_sw_o(div_sw_o),
      .phy_reset_n_o(phy_reset_n_o), .lms_res_o(lms_res_o), .bldr_done_o(bldr_done));

   assign s_dat[SET] = '0;   // Settings page reads as zero

   vita_timer u_timer (
      .wb_clk(wb_clk), .wb_rst_i(wb_rst_o), .set_stb_i(set_stb), .set_addr_i(set_addr),
      .set_data_i(set_data), .pps_i(pps_i), .vita_time_o(vita_time),
      .vita_time_pps_o(vita_time_pps));

   readback_mux u_readback (
      .wb_clk(wb_clk), .wb_rst_i(wb_rst_o), .stb_i(s_stb[RB]),
      .adr_i(bus_adr.pg.offset[5:2]), .vita_time_i(vita_time),
      .vita_time_pps_i(vita_time_pps), .button_i(button_i), .aux_ld_i(aux_ld_i),
      .dat_o(s_dat[RB]), .ack_o(s_ack[RB]));

endmodule

//--- source/umtrx_macros.svh
// Bus widths and map constants for one wb_clk master whose slave pages never overlap
`ifndef UMTRX_MACROS_SVH
`define UMTRX_MACROS_SVH

////////////////////////////////////////
// Bus widths
`define UMTRX_DW      32     // Data bits
`define UMTRX_AW      16     // Byte address over 64K
`define UMTRX_SW      4      // Byte lanes
`define UMTRX_RAM_AW  8      // 256 words per RAM

////////////////////////////////////////
// Slave pages, compared on address bits 15:8
`define SLV_MAIN_BASE 8'h00  // Main RAM at 0K
`define SLV_MAIN_MASK 8'hC0
`define SLV_SET_BASE  8'h70  // Settings bus
`define SLV_SET_MASK  8'hF0
`define SLV_RB_BASE   8'h5C  // Readback words
`define SLV_RB_MASK   8'hFC
`define SLV_BOOT_BASE 8'hC0  // Boot RAM at 48K
`define SLV_BOOT_MASK 8'hC0

////////////////////////////////////////
// Settings register numbers
`define SR_MISC       8'd0   // 7 regs
`define SR_TIME64     8'd10  // Hi stage then lo load
`define SR_DIVSW      8'd180 // 2 switches

// Reset and identity values
`define LED_SRC_RESET 8'h1E  // Run LEDs under hardware control
`define COMPAT_NUM    {16'd9, 16'd0} // Major 9 minor 0

`endif

//--- source/vita_timer.sv
// Time counts wb_clk ticks; the PPS latch trails the pin by the two-flop synchronizer delay
`timescale 1ns/1ns
`include "umtrx_macros.svh"

module vita_timer
   import radio_ctrl_pkg::*;
(
   input  logic        wb_clk,
   input  logic        wb_rst_i,
   input  logic        set_stb_i,
   input  set_addr_t   set_addr_i,
   input  logic [31:0] set_data_i,
   input  logic        pps_i,          // Async pin
   output vita_time_t  vita_time_o,
   output vita_time_t  vita_time_pps_o
);

   logic [31:0] hi_stage_q;   // Waits for the low word
   logic [2:0]  pps_q;        // Two sync flops then history
   logic        pps_rise;
   logic        load_hi;
   logic        load_lo;

   assign load_hi  = set_stb_i && (set_addr_i == `SR_TIME64);
   assign load_lo  = set_stb_i && (set_addr_i == `SR_TIME64 + 8'd1);
   assign pps_rise = pps_q[1] & ~pps_q[2];

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         hi_stage_q      <= '0;
         pps_q           <= '0;
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
      end else begin
         pps_q <= {pps_q[1:0], pps_i};
         if (load_hi) begin
            hi_stage_q <= set_data_i;
         end
         // Low word write commits both halves at once
         if (load_lo) begin
            vita_time_o <= {hi_stage_q, set_data_i};
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
         end
         if (pps_rise) begin
            vita_time_pps_o <= vita_time_o;   // Snapshot on the edge
         end
      end
   end

endmodule

//--- source/wb_bus_pkg.sv
// Bus types for the single-master decoder; addresses are byte addresses of UMTRX_AW bits
`include "umtrx_macros.svh"

package wb_bus_pkg;

   ////////////////////////////////////////
   // One bus address read two ways
   typedef union packed {
      logic [`UMTRX_AW-1:0] flat;   // Whole byte address for the boot swap
      struct packed {
         logic [7:0] page;          // Decoder compares this
         logic [7:0] offset;        // Byte within the page
      } pg;
   } wb_addr_u;

   ////////////////////////////////////////
   // Decoder slots
   typedef enum logic [1:0] {
      MAIN = 2'd0,   // Main RAM
      SET  = 2'd1,   // Settings bus
      RB   = 2'd2,   // Readback mux
      BOOT = 2'd3    // Boot RAM
   } slave_idx_e;

endpackage

//--- source/wb_intercon.sv
// Single master only with no arbitration; slaves see stb with cyc folded in and no err of their own
`timescale 1ns/1ns
`include "umtrx_macros.svh"

module wb_intercon
   import wb_bus_pkg::*;
(
   input  logic                      wb_clk,
   input  logic                      wb_rst_i,
   input  wb_addr_u                  m_adr_i,   // Already swapped
   input  logic                      m_cyc_i,
   input  logic                      m_stb_i,
   output logic                      m_ack_o,
   output logic                      m_err_o,
   output logic [`UMTRX_DW-1:0]      m_dat_o,
   output logic [3:0]                s_stb_o,   // By slave_idx_e
   input  logic [3:0]                s_ack_i,
   input  logic [3:0][`UMTRX_DW-1:0] s_dat_i
);

   logic [3:0] hit;       // One-hot page match
   slave_idx_e sel_idx;   // Read data source
   logic       req;       // Live master request
   logic       err_q;     // Unmapped ack

   assign req = m_cyc_i & m_stb_i;

   ////////////////////////////////////////
   // Page decode
   always_comb begin
      hit       = '0;
      hit[MAIN] = (m_adr_i.pg.page & `SLV_MAIN_MASK) == `SLV_MAIN_BASE;
      hit[SET]  = (m_adr_i.pg.page & `SLV_SET_MASK) == `SLV_SET_BASE;
      hit[RB]   = (m_adr_i.pg.page & `SLV_RB_MASK) == `SLV_RB_BASE;
      hit[BOOT] = (m_adr_i.pg.page & `SLV_BOOT_MASK) == `SLV_BOOT_BASE;
   end

   // Pages are disjoint so any order works here
   always_comb begin
      sel_idx = MAIN;
      if (hit[SET]) begin
         sel_idx = SET;
      end else if (hit[RB]) begin
         sel_idx = RB;
      end else if (hit[BOOT]) begin
         sel_idx = BOOT;
      end
   end

   assign s_stb_o = {4{req}} & hit;      // Strobe only the addressed slave
   assign m_ack_o = |s_ack_i;            // Idle slaves hold ack low
   assign m_dat_o = s_dat_i[sel_idx];    // Master holds adr until ack

   ////////////////////////////////////////
   // Unmapped access
   // Registered like a slave ack so an error costs the same cycle
   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req & ~(|hit) & ~err_q;   // Single cycle pulse
      end
   end

   assign m_err_o = err_q;

endmodule

//--- source/wb_ram.sv
// Single port RAM with registered read; contents are undefined at power up and survive reset
`timescale 1ns/1ns
`include "umtrx_macros.svh"

module wb_ram #(
   parameter int AW = `UMTRX_RAM_AW,   // Word address bits
   parameter int DW = `UMTRX_DW,
   parameter int SW = `UMTRX_SW
) (
   input  logic          wb_clk,
   input  logic          wb_rst_i,
   input  logic          stb_i,
   input  logic          we_i,
   input  logic [SW-1:0] sel_i,
   input  logic [AW-1:0] adr_i,
   input  logic [DW-1:0] dat_i,
   output logic [DW-1:0] dat_o,
   output logic          ack_o
);

   localparam int LW = DW / SW;   // Lane width

   logic [DW-1:0] mem [2**AW];
   logic          acc;

   assign acc = stb_i & ~ack_o;   // One access per strobe

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= acc;
      end
   end

   // Byte lane writes, read data lands with ack
   always_ff @(posedge wb_clk) begin
      if (acc && we_i) begin
         for (int b = 0; b < SW; b++) begin
            if (sel_i[b]) begin
               mem[adr_i][LW*b +: LW] <= dat_i[LW*b +: LW];
            end
         end
      end
      dat_o <= mem[adr_i];   // Old word on a write cycle
   end

endmodule

//--- umtrx_core.f
+incdir+source
source/wb_bus_pkg.sv
source/radio_ctrl_pkg.sv
source/wb_intercon.sv
source/boot_reset_ctrl.sv
source/wb_ram.sv
source/settings_regs.sv
source/vita_timer.sv
source/readback_mux.sv
source/umtrx_core.sv
dv/umtrx_core_tb.sv
